// File: common/muldiv_cfg.svh
// Width, operation codes and divider length for the RISC-V M unit.
// Included by the package and by every RTL file that needs them.
`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// Operand and result width.
`define MULDIV_DATA_WIDTH 32

// funct3 codes of the M extension.
`define MULDIV_FUNCT3_MUL    3'b000 // Signed x signed, low half.
`define MULDIV_FUNCT3_MULH   3'b001 // Signed x signed, high half.
`define MULDIV_FUNCT3_MULHSU 3'b010 // Signed rs1 x unsigned rs2, high half.
`define MULDIV_FUNCT3_MULHU  3'b011 // Unsigned x unsigned, high half.
`define MULDIV_FUNCT3_DIV    3'b100 // Signed quotient.
`define MULDIV_FUNCT3_DIVU   3'b101 // Unsigned quotient.
`define MULDIV_FUNCT3_REM    3'b110 // Signed remainder.
`define MULDIV_FUNCT3_REMU   3'b111 // Unsigned remainder.

// One quotient bit per cycle.
`define MULDIV_DIV_STEPS `MULDIV_DATA_WIDTH

`endif

// File: common/muldiv_pkg.sv
// Shared types of the multiply/divide unit.
// Vector types, block structs and the divider state enum.
`default_nettype none

`include "muldiv_cfg.svh"

package muldiv_pkg;

	//**************************************************
	// Vector types.
	//**************************************************
	typedef logic [`MULDIV_DATA_WIDTH-1:0]   word_t;   // One operand or result.
	typedef logic [2*`MULDIV_DATA_WIDTH-1:0] dword_t;  // Full product.
	typedef logic [2:0]                      funct3_t; // Operation selector.

	//**************************************************
	// Block interfaces.
	//**************************************************
	// Operand preparation output.
	typedef struct packed {
		word_t mag_a;    // Magnitude of rs1.
		word_t mag_b;    // Magnitude of rs2.
		logic  neg_q;    // Negate quotient or full product.
		logic  neg_r;    // Negate remainder or MULHSU product.
		logic  div_zero; // Divisor is zero.
		logic  div_ovf;  // Signed overflow, most negative by minus one.
	} prep_t;

	// Unsigned division result.
	typedef struct packed {
		word_t quo; // Quotient.
		word_t rem; // Remainder.
	} div_result_t;

	// Divider FSM.
	typedef enum logic [1:0] {
		DIV_IDLE = 2'd0, // Never started since reset.
		DIV_RUN  = 2'd1, // Iterating.
		DIV_DONE = 2'd2  // Result held.
	} div_state_t;

endpackage

`default_nettype wire

// File: design/operand_prep.sv
// Operand preparation for the multiply and divide paths.
// Takes magnitudes of signed operands and flags the special division cases.
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module operand_prep (
	input  wire muldiv_pkg::word_t   rs1_i,    // Multiplicand or dividend.
	input  wire muldiv_pkg::word_t   rs2_i,    // Multiplier or divisor.
	input  wire muldiv_pkg::funct3_t funct3_i, // Operation code.
	output muldiv_pkg::prep_t        prep_o    // Magnitudes and sign flags.
);

	localparam int MSB = `MULDIV_DATA_WIDTH - 1;

	logic signed_a; // rs1 is two's complement.
	logic signed_b; // rs2 is two's complement.
	logic neg_a;
	logic neg_b;
	logic signed_div;

	always_comb begin
		// rs1 signed for MUL, MULH, MULHSU, DIV and REM.
		signed_a = (funct3_i == `MULDIV_FUNCT3_MUL) || (funct3_i == `MULDIV_FUNCT3_MULH) ||
			(funct3_i == `MULDIV_FUNCT3_MULHSU) || (funct3_i == `MULDIV_FUNCT3_DIV) ||
			(funct3_i == `MULDIV_FUNCT3_REM);
		// rs2 signed for MUL, MULH, DIV and REM.
		signed_b = (funct3_i == `MULDIV_FUNCT3_MUL) || (funct3_i == `MULDIV_FUNCT3_MULH) ||
			(funct3_i == `MULDIV_FUNCT3_DIV) || (funct3_i == `MULDIV_FUNCT3_REM);
		signed_div = (funct3_i == `MULDIV_FUNCT3_DIV) || (funct3_i == `MULDIV_FUNCT3_REM);

		neg_a = signed_a & rs1_i[MSB]; // Negative rs1.
		neg_b = signed_b & rs2_i[MSB]; // Negative rs2.

		prep_o.mag_a = neg_a ? -rs1_i : rs1_i;
		prep_o.mag_b = neg_b ? -rs2_i : rs2_i;
		prep_o.neg_q = neg_a ^ neg_b;   // Signs differ.
		prep_o.neg_r = neg_a;           // Remainder follows the dividend.
		prep_o.div_zero = (rs2_i == '0);
		// Only the signed codes overflow.
		prep_o.div_ovf = signed_div && (rs1_i == {1'b1, {MSB{1'b0}}}) && (rs2_i == '1);

		// A magnitude keeps its top bit only for the most negative input.
		if (signed_a) begin
			assert (!prep_o.mag_a[MSB] || (rs1_i == {1'b1, {MSB{1'b0}}}))
				else $error("rs1 magnitude out of range");
		end
		if (signed_b) begin
			assert (!prep_o.mag_b[MSB] || (rs2_i == {1'b1, {MSB{1'b0}}}))
				else $error("rs2 magnitude out of range");
		end
	end

endmodule

`default_nettype wire

// File: design/mul_partial_products.sv
// Unsigned 32x32 multiplier built from four 16x16 partial products.
// Fully combinational, fed with operand magnitudes.
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module mul_partial_products (
	input  wire muldiv_pkg::word_t a_i,   // Multiplicand magnitude.
	input  wire muldiv_pkg::word_t b_i,   // Multiplier magnitude.
	output muldiv_pkg::dword_t     prod_o // Unsigned product.
);

	localparam int HW = `MULDIV_DATA_WIDTH / 2; // Half width.

	logic [HW-1:0] a_lo;
	logic [HW-1:0] a_hi;
	logic [HW-1:0] b_lo;
	logic [HW-1:0] b_hi;

	muldiv_pkg::word_t pp_ll; // Weight 2^0.
	muldiv_pkg::word_t pp_lh; // Weight 2^HW.
	muldiv_pkg::word_t pp_hl; // Weight 2^HW.
	muldiv_pkg::word_t pp_hh; // Weight 2^(2*HW).

	logic [`MULDIV_DATA_WIDTH:0] mid_sum; // Cross terms with carry.

	// Operand halves.
	assign a_lo = a_i[HW-1:0];
	assign a_hi = a_i[2*HW-1:HW];
	assign b_lo = b_i[HW-1:0];
	assign b_hi = b_i[2*HW-1:HW];

	//**************************************************
	// Partial products.
	//**************************************************
	assign pp_ll = a_lo * b_lo;
	assign pp_lh = a_lo * b_hi;
	assign pp_hl = a_hi * b_lo;
	assign pp_hh = a_hi * b_hi;

	// The two cross terms share one alignment.
	assign mid_sum = {1'b0, pp_lh} + {1'b0, pp_hl};

	// Outer terms do not overlap, so they concatenate.
	assign prod_o = {pp_hh, pp_ll} + (muldiv_pkg::dword_t'(mid_sum) << HW);

endmodule

`default_nettype wire

// File: divider/div_restoring.sv
// Unsigned restoring divider, one quotient bit per clock.
// Started by a single-cycle pulse; the result holds until the next start.
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module div_restoring (
	input  wire                    clk,
	input  wire                    rstLow,     // Asynchronous, active low.
	input  wire                    start_i,    // One-cycle start pulse.
	input  wire muldiv_pkg::word_t dividend_i, // Unsigned dividend.
	input  wire muldiv_pkg::word_t divisor_i,  // Unsigned divisor, non-zero.
	output muldiv_pkg::div_result_t res_o,     // Quotient and remainder.
	output logic                   busy_o      // High while iterating.
);

	localparam int W  = `MULDIV_DATA_WIDTH;
	localparam int CW = $clog2(`MULDIV_DIV_STEPS);
	localparam logic [CW-1:0] LAST_STEP = CW'(`MULDIV_DIV_STEPS - 1);

	muldiv_pkg::div_state_t state_q;
	logic [CW-1:0]          step_q; // Iteration index.

	muldiv_pkg::word_t dvd_q; // Dividend bits out, quotient bits in.
	muldiv_pkg::word_t dvs_q; // Divisor held for the run.
	muldiv_pkg::word_t rem_q; // Partial remainder.

	logic [W:0] shifted; // Remainder with next dividend bit.
	logic [W:0] diff;    // Trial subtraction.
	logic       q_bit;   // Subtraction fits.
	logic       load;

	assign load   = start_i && (state_q != muldiv_pkg::DIV_RUN);
	assign busy_o = (state_q == muldiv_pkg::DIV_RUN);

	//**************************************************
	// Datapath step.
	//**************************************************
	assign shifted = {rem_q, dvd_q[W-1]};
	assign diff    = shifted - {1'b0, dvs_q};
	assign q_bit   = ~diff[W]; // No borrow, so partial remainder >= divisor.

	// Control FSM.
	always_ff @(posedge clk or negedge rstLow) begin
		if (!rstLow) begin
			state_q <= muldiv_pkg::DIV_IDLE;
			step_q  <= '0;
		end else begin
			case (state_q)
				muldiv_pkg::DIV_IDLE, muldiv_pkg::DIV_DONE: begin
					if (start_i) begin
						state_q <= muldiv_pkg::DIV_RUN;
						step_q  <= '0;
					end
				end
				muldiv_pkg::DIV_RUN: begin
					step_q <= step_q + 1'b1;
					if (step_q == LAST_STEP) state_q <= muldiv_pkg::DIV_DONE; // Last bit.
				end
				default: state_q <= muldiv_pkg::DIV_IDLE;
			endcase
		end
	end

	// Shift registers for dividend, divisor and partial remainder.
	always_ff @(posedge clk) begin
		if (load) begin
			dvd_q <= dividend_i;
			dvs_q <= divisor_i;
			rem_q <= '0; // Fresh partial remainder.
		end else if (state_q == muldiv_pkg::DIV_RUN) begin
			rem_q <= q_bit ? diff[W-1:0] : shifted[W-1:0]; // Restore when too small.
			dvd_q <= {dvd_q[W-2:0], q_bit};
		end
	end

	// Values are final once the FSM leaves RUN.
	assign res_o.quo = dvd_q;
	assign res_o.rem = rem_q;

	// The control block must not restart a running divider.
	a_no_restart: assert property (@(posedge clk) disable iff (!rstLow)
		busy_o |-> !start_i)
		else $error("divider started while busy");

endmodule

`default_nettype wire

// File: divider/div_control.sv
// Divider control. Generates one start pulse per division request, skips
// special cases, serves REM after DIV from stored results and drives busy.
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module div_control (
	input  wire                      clk,
	input  wire                      rstLow,   // Asynchronous, active low.
	input  wire                      start_i,  // Request level from the core.
	input  wire muldiv_pkg::funct3_t funct3_i, // Operation code.
	input  wire muldiv_pkg::word_t   rs1_i,    // Raw dividend.
	input  wire muldiv_pkg::word_t   rs2_i,    // Raw divisor.
	input  wire muldiv_pkg::prep_t   prep_i,   // Magnitudes and special flags.
	output muldiv_pkg::div_result_t  res_o,    // Unsigned quotient and remainder.
	output logic                     busy_o    // Core stall.
);

	muldiv_pkg::word_t       rs1_q;    // Operands of the last started division.
	muldiv_pkg::word_t       rs2_q;
	muldiv_pkg::funct3_t     funct3_q; // Last operation seen.
	muldiv_pkg::div_result_t store_q;  // Result of the last finished division.
	muldiv_pkg::div_result_t div_res;
	logic                    div_busy;
	logic                    div_busy_q; // For the completion edge.
	logic                    issued_q;   // Request already started.
	logic                    is_div;
	logic                    reuse_hit;
	logic                    start_pulse;
	logic [7:0]              busy_run_q; // Consecutive busy cycles.

	assign is_div = (funct3_i == `MULDIV_FUNCT3_DIV) || (funct3_i == `MULDIV_FUNCT3_DIVU) ||
		(funct3_i == `MULDIV_FUNCT3_REM) || (funct3_i == `MULDIV_FUNCT3_REMU);

	// REM after DIV or REMU after DIVU on unchanged operands.
	assign reuse_hit = (((funct3_i == `MULDIV_FUNCT3_REM) && (funct3_q == `MULDIV_FUNCT3_DIV)) ||
		((funct3_i == `MULDIV_FUNCT3_REMU) && (funct3_q == `MULDIV_FUNCT3_DIVU))) &&
		(rs1_i == rs1_q) && (rs2_i == rs2_q);

	assign start_pulse = start_i && is_div && !prep_i.div_zero && !prep_i.div_ovf &&
		!reuse_hit && !issued_q;

	assign busy_o = start_pulse | div_busy; // High from the first cycle.
	assign res_o  = reuse_hit ? store_q : div_res;

	div_restoring u_div_restoring (
		.clk        (clk),
		.rstLow     (rstLow),
		.start_i    (start_pulse),
		.dividend_i (prep_i.mag_a),
		.divisor_i  (prep_i.mag_b),
		.res_o      (div_res),
		.busy_o     (div_busy)
	);

	//**************************************************
	// Reuse memory and start arming.
	//**************************************************
	always_ff @(posedge clk or negedge rstLow) begin
		if (!rstLow) begin
			rs1_q      <= '0;
			rs2_q      <= '0;
			funct3_q   <= `MULDIV_FUNCT3_MUL; // No hit possible after reset.
			store_q    <= '0;
			div_busy_q <= 1'b0;
			issued_q   <= 1'b0;
		end else begin
			div_busy_q <= div_busy;
			if (start_pulse) begin
				rs1_q <= rs1_i; // Raw operands with signedness given by funct3.
				rs2_q <= rs2_i;
			end
			if (!reuse_hit) funct3_q <= funct3_i; // Keep the DIV across its REM.
			if (div_busy_q && !div_busy) store_q <= div_res; // Divider finished.
			// Re-arm once the divider is done and the core drops start.
			if (start_pulse) issued_q <= 1'b1;
			else if (!div_busy && !start_i) issued_q <= 1'b0;
		end
	end

	// Busy length monitor.
	always_ff @(posedge clk or negedge rstLow) begin
		if (!rstLow) busy_run_q <= '0;
		else if (!busy_o) busy_run_q <= '0;
		else if (busy_run_q != '1) busy_run_q <= busy_run_q + 8'd1;
	end

	// Start cycle plus one cycle per step at most.
	a_busy_len: assert property (@(posedge clk) disable iff (!rstLow)
		busy_o |-> (busy_run_q <= 8'(`MULDIV_DIV_STEPS)))
		else $error("busy_o held longer than the divider run");

endmodule

`default_nettype wire

// File: design/result_select.sv
// Result stage. Restores signs on product, quotient and remainder,
// applies the special division results and picks the output by funct3.
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module result_select (
	input  wire muldiv_pkg::funct3_t     funct3_i, // Operation code.
	input  wire muldiv_pkg::word_t       rs1_i,    // Raw dividend for special cases.
	input  wire muldiv_pkg::prep_t       prep_i,   // Sign and special flags.
	input  wire muldiv_pkg::dword_t      prod_i,   // Unsigned product.
	input  wire muldiv_pkg::div_result_t div_i,    // Unsigned quotient and remainder.
	output muldiv_pkg::word_t            c_o       // Result to the core.
);

	localparam int W = `MULDIV_DATA_WIDTH;

	muldiv_pkg::dword_t prod_neg; // Two's complement of the product.
	muldiv_pkg::dword_t prod_s;   // MUL and MULH.
	muldiv_pkg::dword_t prod_su;  // MULHSU.
	muldiv_pkg::word_t  quo_s;
	muldiv_pkg::word_t  rem_s;
	muldiv_pkg::word_t  quo_out;
	muldiv_pkg::word_t  rem_out;

	//**************************************************
	// Sign correction.
	//**************************************************
	assign prod_neg = -prod_i;
	assign prod_s   = prep_i.neg_q ? prod_neg : prod_i; // Signs differ.
	assign prod_su  = prep_i.neg_r ? prod_neg : prod_i; // rs1 negative.

	// Flags are clear for unsigned codes.
	assign quo_s = prep_i.neg_q ? -div_i.quo : div_i.quo;
	assign rem_s = prep_i.neg_r ? -div_i.rem : div_i.rem;

	// Special cases win over the divider.
	always_comb begin
		if (prep_i.div_zero) begin
			quo_out = '1;    // Quotient of all ones.
			rem_out = rs1_i; // Dividend passes through.
		end else if (prep_i.div_ovf) begin
			quo_out = rs1_i; // Most negative value.
			rem_out = '0;
		end else begin
			quo_out = quo_s;
			rem_out = rem_s;
		end
	end

	//**************************************************
	// Output select.
	//**************************************************
	always_comb begin
		case (funct3_i)
			`MULDIV_FUNCT3_MUL:    c_o = prod_s[W-1:0];
			`MULDIV_FUNCT3_MULH:   c_o = prod_s[2*W-1:W];
			`MULDIV_FUNCT3_MULHSU: c_o = prod_su[2*W-1:W];
			`MULDIV_FUNCT3_MULHU:  c_o = prod_i[2*W-1:W];
			`MULDIV_FUNCT3_DIV,
			`MULDIV_FUNCT3_DIVU:   c_o = quo_out;
			default:               c_o = rem_out; // REM and REMU.
		endcase
	end

endmodule

`default_nettype wire

// File: design/muldiv_unit.sv
// Top of the RISC-V M multiply/divide unit.
// The core polls busy_o and holds operands, funct3 and start until it falls.
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
	input  wire                      clk,
	input  wire                      rstLow,   // Asynchronous, active low.
	input  wire muldiv_pkg::word_t   rs1_i,    // Multiplicand or dividend.
	input  wire muldiv_pkg::word_t   rs2_i,    // Multiplier or divisor.
	input  wire muldiv_pkg::funct3_t funct3_i, // Operation code.
	input  wire                      start_i,  // Request level.
	output muldiv_pkg::word_t        c_o,      // Result.
	output logic                     busy_o    // Division in progress.
);

	muldiv_pkg::prep_t       prep;     // Magnitudes and flags.
	muldiv_pkg::dword_t      prod;     // Unsigned product.
	muldiv_pkg::div_result_t div_res;  // Unsigned quotient and remainder.

	// Signed to unsigned.
	operand_prep u_operand_prep (
		.rs1_i    (rs1_i),
		.rs2_i    (rs2_i),
		.funct3_i (funct3_i),
		.prep_o   (prep)
	);

	// Multiply path.
	mul_partial_products u_mul_partial_products (
		.a_i    (prep.mag_a),
		.b_i    (prep.mag_b),
		.prod_o (prod)
	);

	// Divide path, in parallel.
	div_control u_div_control (
		.clk      (clk),
		.rstLow   (rstLow),
		.start_i  (start_i),
		.funct3_i (funct3_i),
		.rs1_i    (rs1_i),
		.rs2_i    (rs2_i),
		.prep_i   (prep),
		.res_o    (div_res),
		.busy_o   (busy_o)
	);

	// Sign fix and output mux.
	result_select u_result_select (
		.funct3_i (funct3_i),
		.rs1_i    (rs1_i),
		.prep_i   (prep),
		.prod_i   (prod),
		.div_i    (div_res),
		.c_o      (c_o)
	);

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
// Clock and reset source for the testbench.
// 4 ns clock, active-low reset held for the first 8 rising edges.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,   // Free-running clock.
	output logic rstLow_o // Asynchronous, active low.
);

	localparam int RESET_CYCLES = 8;

	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o; // Half of 4 ns.
	end

	initial begin
		rstLow_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o); // Release away from the active edge.
		rstLow_o = 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/muldiv_tb.sv
// Self-checking testbench of the multiply/divide unit.
// Reads vectors from testbench/muldiv_patterns.hex relative to the project root.
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_cfg.svh"

module muldiv_tb;

	localparam int MAX_WORDS      = 1024; // Four words per vector.
	localparam int RESET_CYCLES   = 8;
	localparam int CYCLES_PER_VEC = 40;   // Watchdog budget per vector.

	logic                clk;
	logic                rstLow;
	muldiv_pkg::word_t   rs1;
	muldiv_pkg::word_t   rs2;
	muldiv_pkg::funct3_t funct3;
	logic                start;
	muldiv_pkg::word_t   c;
	logic                busy;

	muldiv_pkg::word_t   vec_mem [MAX_WORDS]; // funct3, rs1, rs2, expected.
	int                  n_vec;
	bit                  loaded;
	int                  value_errors;
	int                  busy_errors;
	int                  timeout_errors;

	// Reuse model of the last division code and started operands.
	muldiv_pkg::funct3_t last_f3;
	muldiv_pkg::word_t   last_rs1;
	muldiv_pkg::word_t   last_rs2;

	tb_clock_gen u_clock_gen (
		.clk_o    (clk),
		.rstLow_o (rstLow)
	);

	muldiv_unit UUT (
		.clk      (clk),
		.rstLow   (rstLow),
		.rs1_i    (rs1),
		.rs2_i    (rs2),
		.funct3_i (funct3),
		.start_i  (start),
		.c_o      (c),
		.busy_o   (busy)
	);

	//**************************************************
	// Expected behavior.
	//**************************************************
	// REM after DIV, or REMU after DIVU, on unchanged operands.
	function automatic logic reuse_expected(input muldiv_pkg::funct3_t f3,
		input muldiv_pkg::word_t a, input muldiv_pkg::word_t b);
		logic pair;
		pair = ((f3 == `MULDIV_FUNCT3_REM) && (last_f3 == `MULDIV_FUNCT3_DIV)) ||
			((f3 == `MULDIV_FUNCT3_REMU) && (last_f3 == `MULDIV_FUNCT3_DIVU));
		return pair && (a == last_rs1) && (b == last_rs2);
	endfunction

	// Division codes 4 to 7 run the divider unless special or reused.
	function automatic logic divider_expected(input muldiv_pkg::funct3_t f3,
		input muldiv_pkg::word_t a, input muldiv_pkg::word_t b, input logic hit);
		logic ovf;
		ovf = ((f3 == `MULDIV_FUNCT3_DIV) || (f3 == `MULDIV_FUNCT3_REM)) &&
			(a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
		return f3[2] && (b != '0) && !ovf && !hit;
	endfunction

	task automatic check_result(input int idx, input muldiv_pkg::word_t expected);
		assert (c === expected)
			else begin
				value_errors++;
				$display("[FAIL] c_o vector %0d: expected 0x%h, got 0x%h", idx, expected, c);
			end
	endtask

	// One request, held until busy_o falls, then start released for a cycle.
	task automatic run_vector(input int idx);
		muldiv_pkg::funct3_t f3;
		muldiv_pkg::word_t   a;
		muldiv_pkg::word_t   b;
		muldiv_pkg::word_t   expected;
		logic                hit;
		logic                want_busy;
		int                  busy_cycles;
		f3 = vec_mem[4*idx][2:0];
		a = vec_mem[4*idx+1];
		b = vec_mem[4*idx+2];
		expected = vec_mem[4*idx+3];
		hit = reuse_expected(f3, a, b);
		want_busy = divider_expected(f3, a, b, hit);
		busy_cycles = 0;

		@(posedge clk);
		rs1 <= a;
		rs2 <= b;
		funct3 <= f3;
		start <= 1'b1;

		@(negedge clk); // First cycle of the request.
		assert (busy === want_busy)
			else begin
				busy_errors++;
				$display("[FAIL] busy_o vector %0d: expected 0x%h, got 0x%h",
					idx, want_busy, busy);
			end
		if (!want_busy) check_result(idx, expected); // Same-cycle result.
		while (busy === 1'b1) begin
			busy_cycles++;
			@(negedge clk);
		end
		if (want_busy) begin
			assert (busy_cycles == `MULDIV_DIV_STEPS + 1)
				else begin
					busy_errors++;
					$display("Vector %0d: busy_o stayed high for %0d cycles instead of %0d",
						idx, busy_cycles, `MULDIV_DIV_STEPS + 1);
				end
		end

		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check_result(idx, expected); // Result held after completion.

		if (!hit) last_f3 = f3;
		if (want_busy) begin
			last_rs1 = a;
			last_rs2 = b;
		end
	endtask

	task automatic finish_run();
		$display("Vectors %0d, value errors %0d, busy errors %0d, timeouts %0d",
			n_vec, value_errors, busy_errors, timeout_errors);
		if (value_errors + busy_errors + timeout_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	//**************************************************
	// Main sequence.
	//**************************************************
	initial begin
		rs1 = '0;
		rs2 = '0;
		funct3 = `MULDIV_FUNCT3_MUL;
		start = 1'b0;
		last_f3 = `MULDIV_FUNCT3_MUL; // Reset state, no reuse yet.
		last_rs1 = '0;
		last_rs2 = '0;
		// Empty words never look like a funct3 code.
		for (int i = 0; i < MAX_WORDS; i++) vec_mem[i] = 32'hDEAD_0000 ^ i;
		$readmemh("testbench/muldiv_patterns.hex", vec_mem);
		n_vec = 0;
		while ((n_vec < MAX_WORDS / 4) && (vec_mem[4*n_vec] < 8)) n_vec++;
		loaded = 1'b1;
		assert (n_vec > 0)
			else begin
				value_errors++;
				$display("No vectors were read from the patterns file");
			end

		wait (rstLow === 1'b1);
		@(negedge clk);
		assert (busy === 1'b0)
			else begin
				busy_errors++;
				$display("[FAIL] busy_o after reset: expected 0x0, got 0x%h", busy);
			end
		for (int i = 0; i < n_vec; i++) run_vector(i);
		finish_run();
	end

	// Watchdog.
	initial begin
		wait (loaded === 1'b1);
		repeat (n_vec * CYCLES_PER_VEC + RESET_CYCLES) @(posedge clk);
		timeout_errors++;
		$display("Timeout, the vectors did not complete within %0d cycles",
			n_vec * CYCLES_PER_VEC + RESET_CYCLES);
		finish_run();
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/muldiv_pkg.sv
design/operand_prep.sv
design/mul_partial_products.sv
divider/div_restoring.sv
divider/div_control.sv
design/result_select.sv
design/muldiv_unit.sv
testbench/tb_clock_gen.sv
testbench/muldiv_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module muldiv_tb -f build.f -o muldiv_sim > sim.log 2>&1 &&
	./obj_dir/muldiv_sim >> sim.log 2>&1
grep -qx "=== PASS ===" sim.log && echo "Simulation passed" && exit 0 ||
	{ echo "Simulation failed, see sim.log"; exit 1; }

// File: testbench/muldiv_patterns.hex
// Columns: funct3 rs1 rs2 expected, all hex.
// funct3 0..7 is MUL MULH MULHSU MULHU DIV DIVU REM REMU.
6 00000000 00000000 00000000
0 00000007 00000006 0000002A
1 00000007 00000006 00000000
0 FFFFFFFD 00000005 FFFFFFF1
1 FFFFFFFD 00000005 FFFFFFFF
1 FFFFFFFD FFFFFFFB 00000000
0 00012345 00006789 75CCA2ED
1 FFFF0000 00010000 FFFFFFFF
3 FFFFFFFF FFFFFFFF FFFFFFFE
2 FFFFFFFF FFFFFFFF FFFFFFFF
2 00000002 FFFFFFFF 00000001
0 80000000 FFFFFFFF 80000000
1 80000000 FFFFFFFF 00000000
3 80000000 FFFFFFFF 7FFFFFFF
2 80000000 FFFFFFFF 80000000
4 00000064 00000007 0000000E
4 FFFFFF9C 00000007 FFFFFFF2
6 FFFFFF9C 00000007 FFFFFFFE
4 00000064 FFFFFFF9 FFFFFFF2
6 00000064 FFFFFFF9 00000002
4 FFFFFF9C FFFFFFF9 0000000E
5 FFFFFF9C 00000007 24924916
7 FFFFFF9C 00000007 00000002
5 00000064 00000007 0000000E
6 00000064 00000007 00000002
6 80000001 00000010 FFFFFFF1
4 00001234 00000000 FFFFFFFF
5 00001234 00000000 FFFFFFFF
6 00001234 00000000 00001234
7 FFFFFF9C 00000000 FFFFFF9C
4 80000000 FFFFFFFF 80000000
6 80000000 FFFFFFFF 00000000
7 80000000 FFFFFFFF 80000000
5 80000000 FFFFFFFF 00000000
